// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - src/ex_pkg.sv
  - src/ex_alu.sv
  - src/ex_mult.sv
  - src/ex_fw_ctrl.sv
  - src/ex_lsu_wb.sv
  - src/ex_stage_top.sv
  - target: test
    files:
      - bench/tb_ex_stage.sv

// ==== all.f ====
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_fw_ctrl.sv
src/ex_lsu_wb.sv
src/ex_stage_top.sv
bench/tb_ex_stage.sv

// ==== bench/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int unsigned MUL_LATENCY = 2;
  // cycles before a handshake wait gives up
  localparam int unsigned WAIT_LIMIT  = 20;
  // sample point after the falling edge
  localparam int unsigned SETTLE      = 2;

  logic      clk;
  logic      rst_n;
  alu_req_t  alu_req;
  mul_req_t  mul_req;
  logic      csr_access;
  data_t     csr_rdata;
  logic      regfile_alu_we;
  reg_addr_t regfile_alu_waddr;
  logic      regfile_we;
  reg_addr_t regfile_waddr;
  logic      lsu_en;
  logic      branch_in_ex;
  logic      lsu_ready_ex;
  logic      lsu_err;
  data_t     lsu_rdata;
  logic      wb_ready;
  rf_wr_t    fw_port;
  rf_wr_t    wb_port;
  logic      branch_decision;
  data_t     jump_target;
  logic      ex_valid;
  logic      ex_ready;

  ////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////

  ex_stage_top #(
    .MUL_LATENCY (MUL_LATENCY)
  ) i_ex_stage_top (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .mul_req_i           (mul_req),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .lsu_en_i            (lsu_en),
    .branch_in_ex_i      (branch_in_ex),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .lsu_rdata_i         (lsu_rdata),
    .wb_ready_i          (wb_ready),
    .fw_port_o           (fw_port),
    .wb_port_o           (wb_port),
    .branch_decision_o   (branch_decision),
    .jump_target_o       (jump_target),
    .ex_valid_o          (ex_valid),
    .ex_ready_o          (ex_ready)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  // branch and set-less-than rule from the ISA
  function automatic logic branch_model(input alu_op_e op, input data_t a, input data_t b);
    logic s_lt;
    logic u_lt;
    s_lt = $signed(a) < $signed(b);
    u_lt = a < b;
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return s_lt;
      ALU_GE:            return !s_lt;
      ALU_LTU, ALU_SLTU: return u_lt;
      ALU_GEU:           return !u_lt;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a + ~b + 32'd1;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return data_t'($signed(a) >>> b[4:0]);
      // compares give 0 or 1
      default: return data_t'(branch_model(op, a, b));
    endcase
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_port(input string name, input rf_wr_t got, input rf_wr_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got we=%h addr=0x%h data=0x%h, expected we=%h addr=0x%h data=0x%h",
               name, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // all enables off, all neighbours ready, data buses kept
  task automatic drive_idle();
    alu_req.en        = 1'b0;
    mul_req.en        = 1'b0;
    csr_access        = 1'b0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    lsu_en            = 1'b0;
    branch_in_ex      = 1'b0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    wb_ready          = 1'b1;
  endtask

  task automatic drive_load(input reg_addr_t addr);
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = addr;
    lsu_err       = 1'b0;
  endtask

  // poll once per cycle until the stage accepts
  task automatic wait_ex_ready(output int cycles);
    cycles = 0;
    while (ex_ready !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      #SETTLE;
      cycles++;
    end
    if (ex_ready !== 1'b1) begin
      $display("timeout: ex_ready_o did not rise within %0d cycles", WAIT_LIMIT);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    #SETTLE;
    check_flag("wb_port_o.we", wb_port.we, 1'b0);
    check_flag("ex_valid_o", ex_valid, 1'b0);
    // idle multiplier never stalls
    check_flag("ex_ready_o", ex_ready, 1'b1);
  endtask

  task automatic test_alu_ops();
    alu_op_e op;
    data_t   a;
    data_t   b;
    rf_wr_t  exp;
    for (int i = 0; i < 16; i++) begin
      for (int n = 0; n < 4; n++) begin
        @(negedge clk);
        op                = alu_op_e'(i);
        a                 = $urandom();
        b                 = $urandom();
        alu_req.en        = 1'b1;
        alu_req.op        = op;
        alu_req.a         = a;
        alu_req.b         = b;
        alu_req.c         = $urandom();
        regfile_alu_we    = 1'b1;
        regfile_alu_waddr = reg_addr_t'($urandom());
        #SETTLE;
        exp = '{we: 1'b1, addr: regfile_alu_waddr, data: alu_model(op, a, b)};
        check_port("fw_port_o", fw_port, exp);
        check_flag("ex_valid_o", ex_valid, 1'b1);
        check_flag("ex_ready_o", ex_ready, 1'b1);
      end
    end
    @(negedge clk);
    drive_idle();
  endtask

  task automatic test_branches();
    data_t   pa [6];
    data_t   pb [6];
    data_t   tgt;
    alu_op_e op;
    // equal, smaller, larger, then sign flips
    pa = '{32'h5, 32'h3, 32'h9, 32'hffff_fff0, 32'h10, 32'h8000_0000};
    pb = '{32'h5, 32'h9, 32'h3, 32'h10, 32'hffff_fff0, 32'h7fff_ffff};
    for (int i = 0; i < 6; i++) begin
      for (int k = 10; k < 16; k++) begin
        @(negedge clk);
        op         = alu_op_e'(k);
        tgt        = $urandom();
        alu_req.en = 1'b1;
        alu_req.op = op;
        alu_req.a  = pa[i];
        alu_req.b  = pb[i];
        alu_req.c  = tgt;
        #SETTLE;
        check_flag("branch_decision_o", branch_decision, branch_model(op, pa[i], pb[i]));
        check_data("jump_target_o", jump_target, tgt);
      end
    end
    // branch resolves in EX even with WB stalled
    @(negedge clk);
    branch_in_ex = 1'b1;
    wb_ready     = 1'b0;
    #SETTLE;
    check_flag("ex_ready_o", ex_ready, 1'b1);
    check_flag("ex_valid_o", ex_valid, 1'b0);
    @(negedge clk);
    drive_idle();
  endtask

  task automatic test_mult();
    data_t       a;
    data_t       b;
    int          stall;
    rf_wr_t      exp;
    logic [63:0] full;
    for (int n = 0; n < 3; n++) begin
      @(negedge clk);
      a                 = $urandom();
      b                 = $urandom();
      mul_req.en        = 1'b1;
      mul_req.op        = MUL_LO;
      mul_req.a         = a;
      mul_req.b         = b;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = reg_addr_t'($urandom());
      #SETTLE;
      check_flag("ex_ready_o", ex_ready, 1'b0);
      check_flag("ex_valid_o", ex_valid, 1'b0);
      wait_ex_ready(stall);
      check_data("multiplier stall cycles", data_t'(stall), data_t'(MUL_LATENCY - 1));
      check_flag("ex_valid_o", ex_valid, 1'b1);
      // low word of the full product
      full = {32'b0, a} * {32'b0, b};
      exp  = '{we: 1'b1, addr: regfile_alu_waddr, data: full[XLEN-1:0]};
      check_port("fw_port_o", fw_port, exp);
      @(negedge clk);
      drive_idle();
    end
  endtask

  task automatic test_priority();
    rf_wr_t exp;
    @(negedge clk);
    alu_req.en        = 1'b1;
    alu_req.op        = ALU_ADD;
    alu_req.a         = $urandom();
    alu_req.b         = $urandom();
    csr_access        = 1'b1;
    csr_rdata         = $urandom();
    regfile_alu_we    = 1'b1;
    regfile_alu_waddr = reg_addr_t'($urandom());
    #SETTLE;
    exp = '{we: 1'b1, addr: regfile_alu_waddr, data: csr_rdata};
    check_port("fw_port_o", fw_port, exp);
    check_flag("ex_valid_o", ex_valid, 1'b1);
    // nothing enabled, bus goes to zero
    @(negedge clk);
    drive_idle();
    #SETTLE;
    exp = '{we: 1'b0, addr: '0, data: '0};
    check_port("fw_port_o", fw_port, exp);
    check_flag("ex_valid_o", ex_valid, 1'b0);
  endtask

  task automatic test_load_port();
    reg_addr_t addr;
    rf_wr_t    exp;
    @(negedge clk);
    addr      = reg_addr_t'($urandom());
    lsu_rdata = $urandom();
    drive_load(addr);
    #SETTLE;
    check_flag("ex_valid_o", ex_valid, 1'b1);
    // write port opens one cycle later
    @(negedge clk);
    drive_idle();
    #SETTLE;
    exp = '{we: 1'b1, addr: addr, data: lsu_rdata};
    check_port("wb_port_o", wb_port, exp);
    // idle cycle with WB ready clears it
    @(negedge clk);
    #SETTLE;
    check_flag("wb_port_o.we", wb_port.we, 1'b0);
    // faulting load
    @(negedge clk);
    drive_load(reg_addr_t'($urandom()));
    lsu_err = 1'b1;
    #SETTLE;
    check_flag("ex_valid_o", ex_valid, 1'b1);
    @(negedge clk);
    drive_idle();
    #SETTLE;
    check_flag("wb_port_o.we", wb_port.we, 1'b0);
  endtask

  task automatic test_backpressure();
    reg_addr_t addr_a;
    reg_addr_t addr_b;
    reg_addr_t addr_c;
    rf_wr_t    exp;
    addr_a = 6'h11;
    addr_b = 6'h22;
    addr_c = 6'h33;
    @(negedge clk);
    lsu_rdata = $urandom();
    drive_load(addr_a);
    // next load waits behind a stalled WB
    @(negedge clk);
    drive_load(addr_b);
    wb_ready = 1'b0;
    exp = '{we: 1'b1, addr: addr_a, data: lsu_rdata};
    for (int n = 0; n < 3; n++) begin
      #SETTLE;
      check_flag("ex_valid_o", ex_valid, 1'b0);
      check_flag("ex_ready_o", ex_ready, 1'b0);
      check_port("wb_port_o", wb_port, exp);
      @(negedge clk);
    end
    wb_ready = 1'b1;
    #SETTLE;
    check_flag("ex_valid_o", ex_valid, 1'b1);
    @(negedge clk);
    drive_idle();
    #SETTLE;
    exp = '{we: 1'b1, addr: addr_b, data: lsu_rdata};
    check_port("wb_port_o", wb_port, exp);
    // LSU stall, WB drains and the address is kept
    @(negedge clk);
    drive_load(addr_c);
    lsu_ready_ex = 1'b0;
    exp = '{we: 1'b0, addr: addr_b, data: lsu_rdata};
    for (int n = 0; n < 3; n++) begin
      #SETTLE;
      check_flag("ex_valid_o", ex_valid, 1'b0);
      check_flag("ex_ready_o", ex_ready, 1'b0);
      check_port("wb_port_o", wb_port, exp);
      @(negedge clk);
    end
    lsu_ready_ex = 1'b1;
    #SETTLE;
    check_flag("ex_valid_o", ex_valid, 1'b1);
    @(negedge clk);
    drive_idle();
    #SETTLE;
    exp = '{we: 1'b1, addr: addr_c, data: lsu_rdata};
    check_port("wb_port_o", wb_port, exp);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h22f3_fa32));
    clk       = 1'b0;
    rst_n     = 1'b0;
    alu_req   = '0;
    mul_req   = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    drive_idle();
    // reset for 4 cycles, release on a falling edge
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_alu_ops();
    test_branches();
    test_mult();
    test_priority();
    test_load_port();
    test_backpressure();
    @(negedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== src/ex_stage_top.sv ====
`timescale 1ns/1ps

module ex_stage_top
  import ex_pkg::*;
#(
  parameter int unsigned MUL_LATENCY = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  // requests from ID
  input  alu_req_t  alu_req_i,
  input  mul_req_t  mul_req_i,
  input  logic      csr_access_i,
  input  data_t     csr_rdata_i,
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  // passed to WB, not used in EX
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      lsu_en_i,
  input  logic      branch_in_ex_i,
  // LSU side
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,
  input  data_t     lsu_rdata_i,
  // WB side
  input  logic      wb_ready_i,
  // write ports
  output rf_wr_t    fw_port_o,
  output rf_wr_t    wb_port_o,
  // towards fetch
  output logic      branch_decision_o,
  output data_t     jump_target_o,
  // stage handshake
  output logic      ex_valid_o,
  output logic      ex_ready_o
);

  data_t alu_result;
  data_t mult_result;
  logic  mult_ready;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  // compare flag is the branch decision directly
  ex_alu i_ex_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // operand c carries the precomputed target
  assign jump_target_o = alu_req_i.c;

  ////////////////////////////////////////
  // multiplier
  ////////////////////////////////////////

  ex_mult #(
    .MUL_LATENCY (MUL_LATENCY)
  ) i_ex_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .mul_req_i  (mul_req_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ////////////////////////////////////////
  // forwarding and handshake
  ////////////////////////////////////////

  ex_fw_ctrl i_ex_fw_ctrl (
    .alu_en_i            (alu_req_i.en),
    .mult_en_i           (mul_req_i.en),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .fw_port_o           (fw_port_o),
    .ex_valid_o          (ex_valid_o),
    .ex_ready_o          (ex_ready_o)
  );

  ////////////////////////////////////////
  // EX/WB and load port
  ////////////////////////////////////////

  ex_lsu_wb i_ex_lsu_wb (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .regfile_we_i    (regfile_we_i),
    .lsu_err_i       (lsu_err_i),
    .regfile_waddr_i (regfile_waddr_i),
    .lsu_rdata_i     (lsu_rdata_i),
    .wb_port_o       (wb_port_o)
  );

endmodule

// ==== src/ex_lsu_wb.sv ====
`timescale 1ns/1ps

module ex_lsu_wb
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,
  input  logic      regfile_we_i,
  input  logic      lsu_err_i,
  input  reg_addr_t regfile_waddr_i,
  input  data_t     lsu_rdata_i,
  output rf_wr_t    wb_port_o
);

  logic      we_q;
  reg_addr_t waddr_q;
  logic      load_we;

  // faulting load never writes
  assign load_we = regfile_we_i & ~lsu_err_i;

  ////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else begin
      if (ex_valid_i) begin
        // wb_ready implied by valid
        we_q <= load_we;
      end else if (wb_ready_i) begin
        // WB took the old one, nothing new behind it
        we_q <= 1'b0;
      end
      // else WB stalled, hold
    end
  end

  // address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_i && load_we) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  ////////////////////////////////////////
  // load write port
  ////////////////////////////////////////

  assign wb_port_o.we   = we_q;
  assign wb_port_o.addr = waddr_q;
  // read data arrives from the LSU in the WB cycle
  assign wb_port_o.data = lsu_rdata_i;

  // write port only opens behind a handed-over instruction
  a_we_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_port_o.we) |-> $past(ex_valid_i));

endmodule

// ==== src/ex_fw_ctrl.sv ====
`timescale 1ns/1ps

module ex_fw_ctrl
  import ex_pkg::*;
(
  // unit enables from ID
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      lsu_en_i,
  input  logic      branch_in_ex_i,
  // readiness of units and neighbours
  input  logic      mult_ready_i,
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  // candidate write data
  input  data_t     alu_result_i,
  input  data_t     mult_result_i,
  input  data_t     csr_rdata_i,
  // destination from ID
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  output rf_wr_t    fw_port_o,
  output logic      ex_valid_o,
  output logic      ex_ready_o
);

  logic any_en;
  logic units_ready;

  ////////////////////////////////////////
  // forwarding port
  ////////////////////////////////////////

  // address and enable go straight through
  assign fw_port_o.we   = regfile_alu_we_i;
  assign fw_port_o.addr = regfile_alu_waddr_i;

  // csr wins over mult, mult over alu
  always_comb begin
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.data = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.data = alu_result_i;
    end else begin
      // nothing running, keep the bus quiet
      fw_port_o.data = '0;
    end
  end

  ////////////////////////////////////////
  // stage handshake
  ////////////////////////////////////////

  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // valid flows forward, independent of ex_ready
  assign ex_valid_o = any_en & units_ready;
  // a branch finishes in EX, no need to wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

endmodule

// ==== src/ex_mult.sv ====
`timescale 1ns/1ps

module ex_mult
  import ex_pkg::*;
#(
  parameter int unsigned MUL_LATENCY = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  mul_req_t mul_req_i,
  input  logic     ex_ready_i,
  output data_t    result_o,
  output logic     ready_o
);

  // low 32 bits of the product
  data_t product;

  always_comb begin
    unique case (mul_req_i.op)
      MUL_LO:  product = mul_req_i.a * mul_req_i.b;
      default: product = '0;
    endcase
  end

  if (MUL_LATENCY <= 1) begin : gen_comb
    // single cycle, never stalls
    assign result_o = product;
    assign ready_o  = 1'b1;
  end else begin : gen_seq
    localparam int unsigned CNT_W = $clog2(MUL_LATENCY);

    typedef enum logic [1:0] {
      MUL_IDLE,
      MUL_BUSY,
      MUL_DONE
    } mul_state_e;

    mul_state_e       state_q;
    mul_state_e       state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    data_t            prod_q;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      ready_o = 1'b1;
      unique case (state_q)
        MUL_IDLE: begin
          // stall from the start cycle on
          ready_o = ~mul_req_i.en;
          if (mul_req_i.en) begin
            cnt_d   = CNT_W'(1);
            state_d = (MUL_LATENCY == 2) ? MUL_DONE : MUL_BUSY;
          end
        end
        MUL_BUSY: begin
          ready_o = 1'b0;
          cnt_d   = cnt_q + CNT_W'(1);
          if (cnt_q == CNT_W'(MUL_LATENCY - 2)) begin
            state_d = MUL_DONE;
          end
        end
        MUL_DONE: begin
          // hold result until the stage takes it
          if (ex_ready_i) begin
            state_d = MUL_IDLE;
          end
        end
        default: state_d = MUL_IDLE;
      endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        state_q <= MUL_IDLE;
        cnt_q   <= '0;
      end else begin
        state_q <= state_d;
        cnt_q   <= cnt_d;
      end
    end

    // operands are held by ID, so capture at start is enough
    always_ff @(posedge clk) begin
      if (state_q == MUL_IDLE && mul_req_i.en) begin
        prod_q <= product;
      end
    end

    assign result_o = prod_q;

    // stall lasts exactly latency-1 cycles from start
    a_stall_len: assert property (@(posedge clk) disable iff (!rst_n)
      (state_q == MUL_IDLE && mul_req_i.en)
        |-> (!ready_o) [* MUL_LATENCY-1] ##1 ready_o);
  end

  // no request, no stall
  a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !mul_req_i.en |-> ready_o);

endmodule

// ==== src/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  input  alu_req_t alu_req_i,
  output data_t    result_o,
  output logic     cmp_result_o
);

  ////////////////////////////////////////
  // operand prep
  ////////////////////////////////////////

  data_t      op_a;
  data_t      op_b;
  logic [4:0] shamt;
  data_t      sum;
  data_t      diff;
  logic       is_equal;
  logic       lt_signed;
  logic       lt_unsigned;

  assign op_a  = alu_req_i.a;
  assign op_b  = alu_req_i.b;
  // rv32 shifts use the low five bits only
  assign shamt = op_b[4:0];

  // adder and subtractor kept apart for clarity
  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  // shared comparators
  assign is_equal    = (op_a == op_b);
  assign lt_signed   = ($signed(op_a) < $signed(op_b));
  assign lt_unsigned = (op_a < op_b);

  ////////////////////////////////////////
  // comparison flag
  ////////////////////////////////////////

  // one flag serves slt/sltu and the branch decision
  always_comb begin
    unique case (alu_req_i.op)
      ALU_EQ:           cmp_result_o = is_equal;
      ALU_NE:           cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:  cmp_result_o = lt_signed;
      ALU_GE:           cmp_result_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_GEU:          cmp_result_o = ~lt_unsigned;
      // arithmetic and logic ops never branch
      default:          cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // result mux
  ////////////////////////////////////////

  always_comb begin
    unique case (alu_req_i.op)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = op_a & op_b;
      ALU_OR:  result_o = op_a | op_b;
      ALU_XOR: result_o = op_a ^ op_b;
      // shifts
      ALU_SLL: result_o = op_a << shamt;
      ALU_SRL: result_o = op_a >> shamt;
      // arithmetic right, keep sign
      ALU_SRA: result_o = data_t'($signed(op_a) >>> shamt);
      // set-less-than and compares give the flag zero extended
      ALU_SLT, ALU_SLTU,
      ALU_EQ, ALU_NE,
      ALU_LT, ALU_GE,
      ALU_LTU, ALU_GEU: begin
        result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
      end
      default: result_o = '0;
    endcase
  end

endmodule

// ==== src/ex_pkg.sv ====
package ex_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // datapath width
  parameter int unsigned XLEN       = 32;
  // register address, 6 bits to cover the fp bank
  parameter int unsigned REG_ADDR_W = 6;

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////

  // integer ALU operations, all 16 codes taken
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // branch comparisons
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // multiplier only does the low product
  typedef enum logic [0:0] {
    MUL_LO = 1'b0
  } mul_op_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // ALU request from ID, c is the jump target
  typedef struct packed {
    logic    en;
    alu_op_e op;
    data_t   a;
    data_t   b;
    data_t   c;
  } alu_req_t;

  // multiplier request from ID
  typedef struct packed {
    logic    en;
    mul_op_e op;
    data_t   a;
    data_t   b;
  } mul_req_t;

  // one register-file write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    data_t     data;
  } rf_wr_t;

endpackage
